/* design/tpu_pkg.sv */
`default_nettype none

package tpu_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int DATA_W = 8;                 // operand element
    localparam int ADDR_W = 4;                 // 16 rows per memory
    localparam int ACC_W  = 2 * DATA_W + 2;    // four products never wrap

    typedef logic signed [DATA_W-1:0] data_t;  // one signed operand byte
    typedef logic signed [ACC_W-1:0]  acc_t;   // one accumulated lane
    typedef logic        [ADDR_W-1:0] addr_t;  // memory row address

    // ==================================================
    // controller states
    // ==================================================
    typedef enum logic [1:0] {
        LOAD_IDLE,                             // waiting for fill or drain
        LOAD_FILL,                             // weight mem -> fifo
        LOAD_DRAIN                             // fifo -> array chain
    } load_state_t;

    typedef enum logic [1:0] {
        MULT_IDLE,
        MULT_ISSUE,                            // input rows leaving memory
        MULT_FLUSH                             // waiting on rows in flight
    } mult_state_t;

endpackage

`default_nettype wire

/* design/row_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module row_mem #(
    parameter int ARR_N = 4
) (
    input  logic                             clk,
    input  logic                             wr_en,
    input  tpu_pkg::addr_t                   wr_addr,
    input  tpu_pkg::data_t [ARR_N-1:0]       wr_data,
    input  logic                             rd_en,
    input  tpu_pkg::addr_t                   rd_addr,
    output tpu_pkg::data_t [ARR_N-1:0]       rd_data
);

    localparam int DEPTH = 2 ** tpu_pkg::ADDR_W;

    tpu_pkg::data_t [ARR_N-1:0] mem [DEPTH];    // one full row per address

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;            // host write
        end
    end

    // registered read, holds last row while idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* design/weight_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_fifo #(
    parameter int ARR_N = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  logic                       pop,
    input  tpu_pkg::data_t [ARR_N-1:0] din,
    output tpu_pkg::data_t [ARR_N-1:0] dout
);

    // stage 0 is the newest row, stage ARR_N-1 the oldest
    tpu_pkg::data_t [ARR_N-1:0] stage [ARR_N];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < ARR_N; i++) begin
                stage[i] <= '0;                 // fifo cleared on reset
            end
        end else if (push || pop) begin
            stage[0] <= push ? din : '0;        // pop alone back-fills zeros
            for (int i = 1; i < ARR_N; i++) begin
                stage[i] <= stage[i-1];         // full push drops the oldest
            end
        end
    end

    assign dout = stage[ARR_N-1];               // oldest row out

endmodule

`default_nettype wire

/* design/weight_load_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_load_ctrl #(
    parameter int ARR_N = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           fill_fifo,
    input  logic           drain_fifo,
    input  tpu_pkg::addr_t w_base,
    input  logic           mult_busy,
    output logic           w_rd_en,
    output tpu_pkg::addr_t w_rd_addr,
    output logic           fifo_push,
    output logic           fifo_pop,
    output logic           w_shift,
    output logic           fill_done,
    output logic           drain_done,
    output logic           load_busy
);

    localparam int CNT_W = $clog2(ARR_N + 2);   // counts up to ARR_N+1

    tpu_pkg::load_state_t state;
    logic [CNT_W-1:0]     cnt;                  // single row counter
    tpu_pkg::addr_t       base_q;               // w_base at accept
    logic                 accept_ok;

    assign accept_ok = (state == tpu_pkg::LOAD_IDLE) && !mult_busy;

    always_ff @(posedge clk) begin
        if (accept_ok && fill_fifo) begin
            base_q <= w_base;
        end
    end

    // ==================================================
    // state machine
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= tpu_pkg::LOAD_IDLE;
            cnt        <= '0;
            fill_done  <= 1'b0;
            drain_done <= 1'b0;
        end else begin
            fill_done  <= 1'b0;                 // pulses only
            drain_done <= 1'b0;
            case (state)
                tpu_pkg::LOAD_IDLE: begin
                    cnt <= '0;
                    if (accept_ok && fill_fifo) begin
                        state <= tpu_pkg::LOAD_FILL;
                    end else if (accept_ok && drain_fifo) begin
                        state <= tpu_pkg::LOAD_DRAIN;
                    end
                end
                tpu_pkg::LOAD_FILL: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(ARR_N + 1)) begin  // last push landed
                        state     <= tpu_pkg::LOAD_IDLE;
                        fill_done <= 1'b1;
                    end
                end
                tpu_pkg::LOAD_DRAIN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(ARR_N)) begin      // chain full
                        state      <= tpu_pkg::LOAD_IDLE;
                        drain_done <= 1'b1;
                    end
                end
                default: state <= tpu_pkg::LOAD_IDLE;
            endcase
        end
    end

    // reads on cnt 0..N-1, pushes trail by one for memory latency
    assign w_rd_en   = (state == tpu_pkg::LOAD_FILL) && (cnt < CNT_W'(ARR_N));
    assign w_rd_addr = base_q + tpu_pkg::addr_t'(cnt);
    assign fifo_push = (state == tpu_pkg::LOAD_FILL) && (cnt != '0)
                       && (cnt <= CNT_W'(ARR_N));
    assign w_shift   = (state == tpu_pkg::LOAD_DRAIN) && (cnt < CNT_W'(ARR_N));
    assign fifo_pop  = w_shift;                 // one fifo row per shift
    assign load_busy = (state != tpu_pkg::LOAD_IDLE);

endmodule

`default_nettype wire

/* design/sys_arr.sv */
`timescale 1ns/1ps
`default_nettype none

module sys_arr #(
    parameter int ARR_N = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       w_shift,
    input  tpu_pkg::data_t [ARR_N-1:0] w_in,
    input  logic                       a_valid,
    input  tpu_pkg::data_t [ARR_N-1:0] a_in,
    output logic                       res_valid,
    output tpu_pkg::acc_t  [ARR_N-1:0] res
);

    localparam int LAT = 2 * ARR_N - 1;         // a_in -> res

    tpu_pkg::data_t [ARR_N-1:0] a_gate;         // zeros between rows
    tpu_pkg::data_t [ARR_N-1:0] a_skew;         // lane k late by k
    tpu_pkg::data_t [ARR_N-1:0] wt [ARR_N];     // wt[k] holds weight row k
    tpu_pkg::data_t             a_r [ARR_N][ARR_N-1];  // activations moving right
    tpu_pkg::acc_t              ps  [ARR_N][ARR_N];    // partial sums moving down
    logic [LAT-1:0]             vld_q;

    assign a_gate = a_valid ? a_in : '0;

    // ==================================================
    // input skew
    // ==================================================
    for (genvar k = 0; k < ARR_N; k++) begin : g_skew
        if (k == 0) begin : g_direct
            assign a_skew[0] = a_gate[0];
        end else begin : g_delay
            tpu_pkg::data_t dly [k];
            always_ff @(posedge clk) begin
                dly[0] <= a_gate[k];
                for (int s = 1; s < k; s++) begin
                    dly[s] <= dly[s-1];
                end
            end
            assign a_skew[k] = dly[k-1];
        end
    end

    // weight chain enters at the last row so the first fill row lands in wt[0]
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < ARR_N; k++) begin
                wt[k] <= '0;
            end
        end else if (w_shift) begin
            wt[ARR_N-1] <= w_in;
            for (int k = 0; k < ARR_N - 1; k++) begin
                wt[k] <= wt[k+1];
            end
        end
    end

    // ==================================================
    // mac grid
    // ==================================================
    for (genvar k = 0; k < ARR_N; k++) begin : g_row
        for (genvar j = 0; j < ARR_N; j++) begin : g_col
            tpu_pkg::data_t a_h;                // from the left
            tpu_pkg::acc_t  p_in;               // from above
            tpu_pkg::acc_t  prod;               // sign-extended product
            if (j == 0) begin : g_a_edge
                assign a_h = a_skew[k];
            end else begin : g_a_pass
                assign a_h = a_r[k][j-1];
            end
            if (k == 0) begin : g_p_edge
                assign p_in = '0;
            end else begin : g_p_pass
                assign p_in = ps[k-1][j];
            end
            assign prod = a_h * wt[k][j];
            always_ff @(posedge clk) begin
                ps[k][j] <= p_in + prod;
            end
            if (j < ARR_N - 1) begin : g_a_reg
                always_ff @(posedge clk) begin
                    a_r[k][j] <= a_h;           // last column has no right neighbour
                end
            end
        end
    end

    // ==================================================
    // output deskew
    // ==================================================
    for (genvar j = 0; j < ARR_N; j++) begin : g_deskew
        if (j == ARR_N - 1) begin : g_direct
            assign res[j] = ps[ARR_N-1][j];     // last column already late
        end else begin : g_delay
            tpu_pkg::acc_t dly [ARR_N-1-j];
            always_ff @(posedge clk) begin
                dly[0] <= ps[ARR_N-1][j];
                for (int s = 1; s < ARR_N - 1 - j; s++) begin
                    dly[s] <= dly[s-1];
                end
            end
            assign res[j] = dly[ARR_N-2-j];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[LAT-2:0], a_valid}; // valid rides with the row
        end
    end

    assign res_valid = vld_q[LAT-1];

endmodule

`default_nettype wire

/* design/mult_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_ctrl (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  tpu_pkg::addr_t in_base,
    input  tpu_pkg::addr_t m_rows,              // 0 means 16 rows
    input  logic           load_busy,
    input  logic           res_valid,
    output logic           in_rd_en,
    output tpu_pkg::addr_t in_rd_addr,
    output logic           a_valid,
    output logic           busy,
    output logic           done
);

    tpu_pkg::mult_state_t state;
    tpu_pkg::addr_t       rd_cnt;               // rows issued
    tpu_pkg::addr_t       ret_cnt;              // rows returned
    tpu_pkg::addr_t       base_q;
    tpu_pkg::addr_t       last_q;               // m_rows - 1, wraps for 16
    logic                 accept;

    assign busy   = (state != tpu_pkg::MULT_IDLE) || done;
    assign accept = start && !busy && !load_busy;

    always_ff @(posedge clk) begin
        if (accept) begin
            base_q <= in_base;
            last_q <= m_rows - 1'b1;
        end
    end

    // ==================================================
    // state machine
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= tpu_pkg::MULT_IDLE;
            rd_cnt  <= '0;
            ret_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                tpu_pkg::MULT_IDLE: begin
                    if (accept) begin
                        state   <= tpu_pkg::MULT_ISSUE;
                        rd_cnt  <= '0;
                        ret_cnt <= '0;
                    end
                end
                tpu_pkg::MULT_ISSUE: begin
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_cnt == last_q) begin
                        state <= tpu_pkg::MULT_FLUSH;
                    end
                end
                tpu_pkg::MULT_FLUSH: begin
                    if (res_valid && ret_cnt == last_q) begin  // last row written now
                        state <= tpu_pkg::MULT_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= tpu_pkg::MULT_IDLE;
            endcase
            // long runs return rows while still issuing
            if (state != tpu_pkg::MULT_IDLE && res_valid) begin
                ret_cnt <= ret_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_valid <= 1'b0;
        end else begin
            a_valid <= in_rd_en;                // matches memory latency
        end
    end

    assign in_rd_en   = (state == tpu_pkg::MULT_ISSUE);
    assign in_rd_addr = base_q + rd_cnt;

endmodule

`default_nettype wire

/* design/relu_out_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module relu_out_mem #(
    parameter int ARR_N = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,    // accepted start only
    input  tpu_pkg::addr_t            out_base,
    input  logic                      res_valid,
    input  tpu_pkg::acc_t [ARR_N-1:0] res,
    input  tpu_pkg::addr_t            rd_addr,
    output tpu_pkg::acc_t [ARR_N-1:0] rd_data
);

    localparam int DEPTH = 2 ** tpu_pkg::ADDR_W;

    tpu_pkg::acc_t [ARR_N-1:0] mem [DEPTH];
    tpu_pkg::acc_t [ARR_N-1:0] clamped;
    tpu_pkg::addr_t            base_q;
    tpu_pkg::addr_t            wr_cnt;          // result row index

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            base_q <= '0;
            wr_cnt <= '0;
        end else if (start) begin
            base_q <= out_base;
            wr_cnt <= '0;
        end else if (res_valid) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    // relu per lane
    always_comb begin
        for (int j = 0; j < ARR_N; j++) begin
            clamped[j] = (res[j] < 0) ? '0 : res[j];
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            mem[base_q + wr_cnt] <= clamped;    // no stall, write on arrival
        end
        rd_data <= mem[rd_addr];                // host read, one cycle
    end

endmodule

`default_nettype wire

/* design/tpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tpu_top #(
    parameter int ARR_N = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_wr_en,
    input  tpu_pkg::addr_t             in_wr_addr,
    input  tpu_pkg::data_t [ARR_N-1:0] in_wr_data,
    input  logic                       w_wr_en,
    input  tpu_pkg::addr_t             w_wr_addr,
    input  tpu_pkg::data_t [ARR_N-1:0] w_wr_data,
    input  logic                       fill_fifo,
    input  logic                       drain_fifo,
    input  tpu_pkg::addr_t             w_base,
    input  logic                       start,
    input  tpu_pkg::addr_t             in_base,
    input  tpu_pkg::addr_t             out_base,
    input  tpu_pkg::addr_t             m_rows,
    input  tpu_pkg::addr_t             out_rd_addr,
    output tpu_pkg::acc_t  [ARR_N-1:0] out_rd_data,
    output logic                       fill_done,
    output logic                       drain_done,
    output logic                       busy,
    output logic                       done
);

    // ==================================================
    // local nets
    // ==================================================
    logic                       w_rd_en, in_rd_en;
    tpu_pkg::addr_t             w_rd_addr, in_rd_addr;
    tpu_pkg::data_t [ARR_N-1:0] w_rd_data, in_rd_data;
    tpu_pkg::data_t [ARR_N-1:0] fifo_dout;
    logic                       fifo_push, fifo_pop, w_shift, load_busy;
    logic                       a_valid, res_valid, start_acc;
    tpu_pkg::acc_t  [ARR_N-1:0] res;

    // output side must ignore a start the controller drops
    assign start_acc = start && !busy && !load_busy;

    row_mem #(.ARR_N(ARR_N)) in_mem (
        .clk(clk), .wr_en(in_wr_en), .wr_addr(in_wr_addr), .wr_data(in_wr_data),
        .rd_en(in_rd_en), .rd_addr(in_rd_addr), .rd_data(in_rd_data)
    );

    row_mem #(.ARR_N(ARR_N)) w_mem (
        .clk(clk), .wr_en(w_wr_en), .wr_addr(w_wr_addr), .wr_data(w_wr_data),
        .rd_en(w_rd_en), .rd_addr(w_rd_addr), .rd_data(w_rd_data)
    );

    // ==================================================
    // weight path
    // ==================================================
    weight_load_ctrl #(.ARR_N(ARR_N)) u_load (
        .clk(clk), .rst_n(rst_n), .fill_fifo(fill_fifo), .drain_fifo(drain_fifo),
        .w_base(w_base), .mult_busy(busy), .w_rd_en(w_rd_en), .w_rd_addr(w_rd_addr),
        .fifo_push(fifo_push), .fifo_pop(fifo_pop), .w_shift(w_shift),
        .fill_done(fill_done), .drain_done(drain_done), .load_busy(load_busy)
    );

    weight_fifo #(.ARR_N(ARR_N)) u_fifo (
        .clk(clk), .rst_n(rst_n), .push(fifo_push), .pop(fifo_pop),
        .din(w_rd_data), .dout(fifo_dout)
    );

    // ==================================================
    // data path
    // ==================================================
    mult_ctrl u_mult (
        .clk(clk), .rst_n(rst_n), .start(start), .in_base(in_base), .m_rows(m_rows),
        .load_busy(load_busy), .res_valid(res_valid), .in_rd_en(in_rd_en),
        .in_rd_addr(in_rd_addr), .a_valid(a_valid), .busy(busy), .done(done)
    );

    sys_arr #(.ARR_N(ARR_N)) u_arr (
        .clk(clk), .rst_n(rst_n), .w_shift(w_shift), .w_in(fifo_dout),
        .a_valid(a_valid), .a_in(in_rd_data), .res_valid(res_valid), .res(res)
    );

    relu_out_mem #(.ARR_N(ARR_N)) u_out (
        .clk(clk), .rst_n(rst_n), .start(start_acc), .out_base(out_base),
        .res_valid(res_valid), .res(res), .rd_addr(out_rd_addr), .rd_data(out_rd_data)
    );

endmodule

`default_nettype wire

/* test/tpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tpu_checker (
    input logic clk,
    input logic rst_n,
    input logic fill_done,
    input logic drain_done,
    input logic done,
    input logic busy,
    input logic start,
    input logic load_busy,
    input logic w_shift
);

    int err_cnt = 0;                            // failed assertions so far

    // ==================================================
    // control pulses
    // ==================================================
    a_fill_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        fill_done |=> !fill_done)
        else begin
            $error("fill_done longer than one cycle");
            err_cnt = err_cnt + 1;
        end

    a_drain_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        drain_done |=> !drain_done)
        else begin
            $error("drain_done longer than one cycle");
            err_cnt = err_cnt + 1;
        end

    a_done_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            $error("done longer than one cycle");
            err_cnt = err_cnt + 1;
        end

    // busy only follows a start the mult side could take
    a_busy_rise : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> $past(start && !load_busy))
        else begin
            $error("busy rose without an accepted start");
            err_cnt = err_cnt + 1;
        end

    a_no_shift_busy : assert property (@(posedge clk) disable iff (!rst_n)
        !(w_shift && busy))
        else begin
            $error("weights shifted during a multiply");
            err_cnt = err_cnt + 1;
        end

endmodule

bind tpu_top tpu_checker chk (
    .clk(clk), .rst_n(rst_n), .fill_done(fill_done), .drain_done(drain_done),
    .done(done), .busy(busy), .start(start), .load_busy(load_busy), .w_shift(w_shift)
);

`default_nettype wire

/* test/tpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tpu_tb;

    localparam int N       = 4;
    localparam int ROWS    = 16;
    localparam int NTEST   = 6;
    localparam int TIMEOUT = 200;               // cycles allowed per wait
    localparam int M_NEG   = 1;                 // negative weights and positive inputs
    localparam int M_IDENT = 2;                 // identity weights

    logic                       clk;
    logic                       rst_n;
    logic                       in_wr_en, w_wr_en;
    tpu_pkg::addr_t             in_wr_addr, w_wr_addr;
    tpu_pkg::data_t [N-1:0]     in_wr_data, w_wr_data;
    logic                       fill_fifo, drain_fifo, start;
    tpu_pkg::addr_t             w_base, in_base, out_base, m_rows, out_rd_addr;
    tpu_pkg::acc_t  [N-1:0]     out_rd_data;
    logic                       fill_done, drain_done, busy, done;

    // nibble fields w_base in_base out_base m_rows reload mode gate
    logic [27:0] stim_tbl [NTEST] = '{
        28'h0_0_0_4_1_0_0,                      // random baseline
        28'h4_4_8_3_0_0_0,                      // reuse weights while new w rows sit unused
        28'h4_8_4_5_1_1_0,                      // negative weights clamp to zero
        28'h8_2_c_6_1_2_0,                      // identity with output wrap
        28'hc_e_3_0_1_0_0,                      // 16 rows with input wrap
        28'h0_9_6_2_0_0_1                       // second start while busy
    };

    logic [31:0] lfsr_q = 32'he5094c11;
    int          in_img  [ROWS][N];             // input memory image
    int          w_img   [ROWS][N];             // weight memory image
    int          cur_w   [N][N];                // weights sitting in the array
    int          exp_out [ROWS][N];
    bit          out_known [ROWS];              // row written at least once

    tpu_top #(.ARR_N(N)) dut (
        .clk(clk), .rst_n(rst_n),
        .in_wr_en(in_wr_en), .in_wr_addr(in_wr_addr), .in_wr_data(in_wr_data),
        .w_wr_en(w_wr_en), .w_wr_addr(w_wr_addr), .w_wr_data(w_wr_data),
        .fill_fifo(fill_fifo), .drain_fifo(drain_fifo), .w_base(w_base),
        .start(start), .in_base(in_base), .out_base(out_base), .m_rows(m_rows),
        .out_rd_addr(out_rd_addr), .out_rd_data(out_rd_data),
        .fill_done(fill_done), .drain_done(drain_done), .busy(busy), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period
    end

    // ==================================================
    // helpers
    // ==================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b      = {lfsr_q[0], b[7:1]};       // one step per bit
            lfsr_q = lfsr_next(lfsr_q);
        end
        return b;
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;                                     // drive and sample point
    endtask

    task automatic check_value(input string name, input int expected,
                               input logic signed [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic flag_of(input int which);
        case (which)
            0:       return fill_done;
            1:       return drain_done;
            default: return done;
        endcase
    endfunction

    // counts edges after the accepting edge
    task automatic wait_flag(input int which, input string what, output int cycles);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            tick();
            n++;
            seen = flag_of(which);
        end
        if (!seen) begin
            $display("timeout: %s never arrived within %0d cycles", what, TIMEOUT);
            $display("Simulation failed");
            $fatal(1, "wait timed out");
        end
        cycles = n;
    endtask

    task automatic write_rows(input int mode, input int wb, input int ib, input int rows);
        logic [7:0] b;
        for (int k = 0; k < N; k++) begin
            for (int j = 0; j < N; j++) begin
                b = rand_byte();
                if (mode == M_NEG) b = {1'b1, b[6:0]};
                if (mode == M_IDENT) b = (k == j) ? 8'd1 : 8'd0;
                w_img[(wb + k) % ROWS][j] = $signed(b);
                w_wr_data[j] = b;
            end
            w_wr_en   = 1'b1;
            w_wr_addr = tpu_pkg::addr_t'(wb + k);
            tick();
        end
        w_wr_en = 1'b0;
        for (int r = 0; r < rows; r++) begin
            for (int j = 0; j < N; j++) begin
                b = rand_byte();
                if (mode == M_NEG) b = {1'b0, b[6:0]};
                in_img[(ib + r) % ROWS][j] = $signed(b);
                in_wr_data[j] = b;
            end
            in_wr_en   = 1'b1;
            in_wr_addr = tpu_pkg::addr_t'(ib + r);
            tick();
        end
        in_wr_en = 1'b0;
    endtask

    // relu of the signed dot product for lane j
    function automatic int model_lane(input int row, input int j);
        int sum;
        sum = 0;
        for (int k = 0; k < N; k++) begin
            sum += in_img[row][k] * cur_w[k][j];
        end
        return (sum < 0) ? 0 : sum;
    endfunction

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        int   wb, ib, ob, mr, rows, mode, cyc;
        logic reload, gate;
        rst_n       = 1'b0;
        in_wr_en    = 1'b0;
        in_wr_addr  = '0;
        in_wr_data  = '0;
        w_wr_en     = 1'b0;
        w_wr_addr   = '0;
        w_wr_data   = '0;
        fill_fifo   = 1'b0;
        drain_fifo  = 1'b0;
        w_base      = '0;
        start       = 1'b0;
        in_base     = '0;
        out_base    = '0;
        m_rows      = '0;
        out_rd_addr = '0;
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;
        tick();
        for (int t = 0; t < NTEST; t++) begin
            wb     = stim_tbl[t][27:24];
            ib     = stim_tbl[t][23:20];
            ob     = stim_tbl[t][19:16];
            mr     = stim_tbl[t][15:12];
            reload = stim_tbl[t][8];
            mode   = stim_tbl[t][7:4];
            gate   = stim_tbl[t][0];
            rows   = (mr == 0) ? ROWS : mr;     // 0 means 16
            write_rows(mode, wb, ib, rows);
            if (reload) begin
                w_base    = tpu_pkg::addr_t'(wb);
                fill_fifo = 1'b1;
                tick();
                fill_fifo = 1'b0;
                wait_flag(0, "fill_done", cyc);
                check_value("fill_done latency", N + 2, cyc);
                drain_fifo = 1'b1;
                tick();
                drain_fifo = 1'b0;
                wait_flag(1, "drain_done", cyc);
                check_value("drain_done latency", N + 1, cyc);
                for (int k = 0; k < N; k++) begin
                    for (int j = 0; j < N; j++) begin
                        cur_w[k][j] = w_img[(wb + k) % ROWS][j];
                    end
                end
            end
            in_base  = tpu_pkg::addr_t'(ib);
            out_base = tpu_pkg::addr_t'(ob);
            m_rows   = tpu_pkg::addr_t'(mr);
            start    = 1'b1;
            tick();
            start = 1'b0;
            if (gate) begin
                repeat (3) tick();
                check_value("busy", 1, busy);
                in_base    = '0;                // would hit other rows if taken
                out_base   = tpu_pkg::addr_t'(ob + 8);
                m_rows     = 4'd1;
                start      = 1'b1;
                drain_fifo = 1'b1;              // empty fifo would zero the weights
                tick();
                start      = 1'b0;
                drain_fifo = 1'b0;
            end
            wait_flag(2, "done", cyc);
            repeat (2 * N + 4) begin            // no second done
                tick();
                check_value("done", 0, done);
                check_value("busy", 0, busy);
            end
            for (int r = 0; r < rows; r++) begin
                for (int j = 0; j < N; j++) begin
                    exp_out[(ob + r) % ROWS][j] = model_lane((ib + r) % ROWS, j);
                end
                out_known[(ob + r) % ROWS] = 1'b1;
            end
            for (int a = 0; a < ROWS; a++) begin
                if (out_known[a]) begin
                    out_rd_addr = tpu_pkg::addr_t'(a);
                    tick();
                    for (int j = 0; j < N; j++) begin
                        check_value($sformatf("out_rd_data[%0d] lane %0d", a, j),
                                    exp_out[a][j], out_rd_data[j]);
                    end
                end
            end
        end
        if (dut.chk.err_cnt == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("checker reported %0d assertion failures", dut.chk.err_cnt);
            $display("Simulation failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
design/tpu_pkg.sv
design/row_mem.sv
design/weight_fifo.sv
design/weight_load_ctrl.sv
design/sys_arr.sv
design/mult_ctrl.sv
design/relu_out_mem.sv
design/tpu_top.sv
test/tpu_checker.sv
test/tpu_tb.sv
